//--- files.f
hw/sms_pkg.sv
hw/vdp_bus_if.sv
hw/sms_io_decode.sv
hw/vdp_ctrl_regs.sv
hw/vdp_vram.sv
hw/vdp_status.sv
hw/sms_io_top.sv
sim/sms_io_checker.sv
sim/tb_sms_io.sv

//--- Makefile
TOP = tb_sms_io

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f files.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_sms_io.sv
`timescale 1ns/1ps

module tb_sms_io;

  import sms_pkg::*;

  logic        cpuClock;
  logic        n_hard_reset;
  logic        io_wr;
  logic        io_rd;
  byte_t       port;
  byte_t       wdata;
  logic [6:0]  btn;
  logic        frame_irq;
  logic        sprite_collision;
  logic        too_many_sprites;
  logic [4:0]  sprite5;
  byte_t       rdata;
  logic        rd_valid;
  byte_t       mem_ctrl;
  logic        n_int;
  vdp_mode_e   mode;
  vdp_addr_t   name_table_addr;
  vdp_addr_t   sprite_pattern_addr;

  logic [31:0] lfsr = 32'd89605;
  int          access_count = 0;
  int          cycle_count = 0;
  logic [13:0] run_addr;
  logic [31:0] rnd;

  sms_io_top i_sms_io_top (
    .cpuClock(cpuClock), .n_hard_reset(n_hard_reset),
    .i_io_wr(io_wr), .i_io_rd(io_rd), .i_port(port), .i_wdata(wdata), .i_btn(btn),
    .i_frame_irq(frame_irq), .i_sprite_collision(sprite_collision),
    .i_too_many_sprites(too_many_sprites), .i_sprite5(sprite5),
    .o_rdata(rdata), .o_rd_valid(rd_valid), .o_mem_ctrl(mem_ctrl), .o_n_int(n_int),
    .o_mode(mode), .o_name_table_addr(name_table_addr),
    .o_sprite_pattern_addr(sprite_pattern_addr)
  );

  sms_io_checker i_checker (
    .cpuClock(cpuClock), .n_hard_reset(n_hard_reset),
    .i_io_wr(io_wr), .i_io_rd(io_rd), .i_port(port), .i_wdata(wdata), .i_btn(btn),
    .i_frame_irq(frame_irq), .i_sprite_collision(sprite_collision),
    .i_too_many_sprites(too_many_sprites), .i_sprite5(sprite5),
    .i_rdata(rdata), .i_rd_valid(rd_valid), .i_mem_ctrl(mem_ctrl), .i_n_int(n_int),
    .i_mode(mode), .i_name_table_addr(name_table_addr),
    .i_sprite_pattern_addr(sprite_pattern_addr)
  );

  initial begin
    cpuClock = 1'b0;
    forever #5 cpuClock = ~cpuClock;
  end

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // ====================
  // Bus tasks
  // ====================
  // Called on a falling edge and returns on the next one
  task automatic io_write(input byte_t p, input byte_t d);
    io_wr = 1'b1;
    port  = p;
    wdata = d;
    access_count++;
    @(negedge cpuClock);
    io_wr = 1'b0;
  endtask

  task automatic io_read(input byte_t p);
    io_rd = 1'b1;
    port  = p;
    access_count++;
    @(negedge cpuClock);
    io_rd = 1'b0;
  endtask

  task automatic set_reg(input int idx, input byte_t val);
    io_write(VDP_CTRL_PORT, val);
    io_write(VDP_CTRL_PORT, {4'h8, 4'(idx)});
  endtask

  task automatic set_addr(input logic [1:0] cmd, input logic [13:0] a);
    io_write(VDP_CTRL_PORT, a[7:0]);
    io_write(VDP_CTRL_PORT, {cmd, a[13:8]});
  endtask

  task automatic write_read_run(input logic [1:0] cmd, input logic [13:0] a);
    set_addr(cmd, a);
    for (int i = 0; i < 8; i++) begin
      take_bits(8, rnd);
      io_write(VDP_DATA_PORT, rnd[7:0]);
    end
    set_addr(cmd == 2'd3 ? 2'd3 : 2'd0, a);
    for (int i = 0; i < 8; i++) io_read(VDP_DATA_PORT);
  endtask

  always @(posedge cpuClock) begin
    cycle_count++;
    if (cycle_count > 20 * access_count + 200) begin
      $display("Timeout after %0d cycles", cycle_count);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    n_hard_reset = 1'b0;
    io_wr = 1'b0;
    io_rd = 1'b0;
    port = '0;
    wdata = '0;
    btn = '0;
    frame_irq = 1'b0;
    sprite_collision = 1'b0;
    too_many_sprites = 1'b0;
    sprite5 = '0;
    repeat (10) @(negedge cpuClock);
    n_hard_reset = 1'b1;
    @(negedge cpuClock);

    i_checker.test_name = "mem_ctrl";
    take_bits(8, rnd);
    io_write(MEM_CTRL_PORT, rnd[7:0]);

    i_checker.test_name = "modes";
    take_bits(16, rnd);
    set_reg(2, rnd[7:0]);
    set_reg(6, rnd[15:8]);
    set_reg(1, 8'h10);  // Mode 1
    set_reg(1, 8'h00);
    set_reg(0, 8'h02);  // Mode 2
    set_reg(0, 8'h00);
    set_reg(1, 8'h08);  // Mode 3
    set_reg(1, 8'h00);
    set_reg(0, 8'h04);  // Mode 4
    take_bits(8, rnd);
    set_reg(6, rnd[7:0]);
    set_reg(11, 8'h5A);  // Index out of range
    set_reg(15, 8'hA5);

    i_checker.test_name = "vram";
    take_bits(14, rnd);
    write_read_run(2'd1, rnd[13:0]);
    i_checker.test_name = "cram";
    take_bits(5, rnd);
    run_addr = {9'b0, rnd[4:0]};
    write_read_run(2'd1, run_addr);  // VRAM bytes under the CRAM pointer
    write_read_run(2'd3, run_addr);
    set_addr(2'd0, run_addr);
    for (int i = 0; i < 8; i++) io_read(VDP_DATA_PORT);

    i_checker.test_name = "joypad";
    take_bits(7, rnd);
    btn = rnd[6:0];
    io_read(JOY_PORT_0);
    io_read(JOY_PORT_1);
    io_read(JOY_PORT_2);
    io_read(8'h00);
    io_read(8'h7F);

    i_checker.test_name = "status";
    set_reg(1, 8'h00);
    frame_irq = 1'b1;
    @(negedge cpuClock);
    frame_irq = 1'b0;
    io_read(VDP_CTRL_PORT);
    io_read(VDP_CTRL_PORT);
    set_reg(1, 8'h20);  // Frame interrupt enable
    take_bits(5, rnd);
    too_many_sprites = 1'b1;
    sprite5 = rnd[4:0];
    frame_irq = 1'b1;
    sprite_collision = 1'b1;
    @(negedge cpuClock);
    frame_irq = 1'b0;
    sprite_collision = 1'b0;
    @(negedge cpuClock);
    io_read(VDP_CTRL_PORT);
    io_read(VDP_CTRL_PORT);
    too_many_sprites = 1'b0;

    i_checker.test_name = "latch";
    set_reg(0, 8'h00);
    io_write(VDP_CTRL_PORT, 8'h33);
    io_read(VDP_CTRL_PORT);
    io_write(VDP_CTRL_PORT, 8'h10);
    io_write(VDP_CTRL_PORT, 8'h81);
    repeat (4) @(negedge cpuClock);

    $display("Checks done: %0d errors in %0d accesses", i_checker.error_count, access_count);
    if (i_checker.error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- sim/sms_io_checker.sv
`timescale 1ns/1ps

module sms_io_checker (
  input logic               cpuClock,
  input logic               n_hard_reset,
  input logic               i_io_wr,
  input logic               i_io_rd,
  input sms_pkg::byte_t     i_port,
  input sms_pkg::byte_t     i_wdata,
  input logic [6:0]         i_btn,
  input logic               i_frame_irq,
  input logic               i_sprite_collision,
  input logic               i_too_many_sprites,
  input logic [4:0]         i_sprite5,
  input sms_pkg::byte_t     i_rdata,
  input logic               i_rd_valid,
  input sms_pkg::byte_t     i_mem_ctrl,
  input logic               i_n_int,
  input sms_pkg::vdp_mode_e i_mode,
  input sms_pkg::vdp_addr_t i_name_table_addr,
  input sms_pkg::vdp_addr_t i_sprite_pattern_addr
);

  import sms_pkg::*;

  string     test_name = "reset";
  int        error_count = 0;

  // Model state
  byte_t     m_regs [VDP_NUM_REGS];
  byte_t     m_vram [2**VRAM_AW];
  byte_t     m_cram [2**CRAM_AW];
  byte_t     m_first;
  logic      m_second;
  vdp_addr_t m_addr;
  logic      m_cram_sel;
  logic      m_int;
  logic      m_coll;
  byte_t     m_mem_ctrl;
  logic      m_init = 1'b0;
  logic      exp_valid = 1'b0;
  byte_t     exp_byte;
  byte_t     exp_port;

  // ====================
  // Reference
  // ====================
  function automatic byte_t ref_read(input byte_t port);
    if (port == VDP_CTRL_PORT) begin
      return {m_int, i_too_many_sprites, m_coll, (i_too_many_sprites ? i_sprite5 : 5'h1F)};
    end else if (port == JOY_PORT_0 || port == JOY_PORT_1 || port == JOY_PORT_2) begin
      return {~i_btn[2:1], ~i_btn[6:1]};  // Pad is active low
    end else if (port == VDP_DATA_PORT) begin
      return m_cram_sel ? m_cram[m_addr[CRAM_AW-1:0]] : m_vram[m_addr];
    end
    return OPEN_BUS;
  endfunction

  function automatic vdp_mode_e ref_mode();
    if (m_regs[0][2]) return MODE_4;
    if (m_regs[1][3]) return MODE_3;
    if (m_regs[0][1]) return MODE_2;
    if (m_regs[1][4]) return MODE_1;
    return MODE_0;
  endfunction

  function automatic vdp_addr_t ref_sprite_base();
    if (ref_mode() == MODE_4) begin
      return {m_regs[6][2], 13'b0};  // 8K steps in mode 4
    end
    return {m_regs[6][2:0], 11'b0};
  endfunction

  task automatic compare(input string what, input logic [15:0] exp, input logic [15:0] act);
    if (exp !== act) begin
      error_count++;
      $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic set_cram_ptr();
    m_addr     = {8'b0, m_first[5:0]};
    m_cram_sel = 1'b1;
  endtask

  // ====================
  // Model update
  // ====================
  always @(posedge cpuClock) begin
    logic ctrl_wr;
    logic ctrl_rd;
    logic data_acc;
    int   idx;
    ctrl_wr  = i_io_wr && (i_port == VDP_CTRL_PORT);
    ctrl_rd  = i_io_rd && (i_port == VDP_CTRL_PORT);
    data_acc = (i_io_wr || i_io_rd) && (i_port == VDP_DATA_PORT);
    idx      = int'(i_wdata[3:0]);
    m_init   = 1'b1;
    if (!n_hard_reset) begin
      for (int i = 0; i < VDP_NUM_REGS; i++) begin
        m_regs[i] = '0;
      end
      m_first    = '0;
      m_second   = 1'b0;
      m_addr     = '0;
      m_cram_sel = 1'b0;
      m_int      = 1'b0;
      m_coll     = 1'b0;
      m_mem_ctrl = MEM_CTRL_RESET;
      exp_valid  = 1'b0;
    end else begin
      exp_valid = i_io_rd;
      exp_byte  = ref_read(i_port);  // Before pointer step and flag clear
      exp_port  = i_port;
      if (ctrl_wr) begin
        if (!m_second) begin
          m_first  = i_wdata;
          m_second = 1'b1;
        end else begin
          m_second = 1'b0;
          case (i_wdata[7:6])
            2'd0, 2'd1: begin
              m_addr     = {i_wdata[5:0], m_first};
              m_cram_sel = 1'b0;
            end
            2'd2: begin
              if (idx < VDP_NUM_REGS) m_regs[idx] = m_first;
              else set_cram_ptr();
            end
            default: set_cram_ptr();
          endcase
        end
      end else if (ctrl_rd) begin
        m_second = 1'b0;
      end else if (data_acc) begin
        if (i_io_wr && m_cram_sel) m_cram[m_addr[CRAM_AW-1:0]] = i_wdata;
        else if (i_io_wr) m_vram[m_addr] = i_wdata;
        m_second = 1'b0;
        m_addr   = m_addr + 14'd1;
      end
      if (i_io_wr && i_port == MEM_CTRL_PORT) m_mem_ctrl = i_wdata;
      m_int  = i_frame_irq || (m_int && !ctrl_rd);
      m_coll = i_sprite_collision || (m_coll && !ctrl_rd);
    end
  end

  // ====================
  // Compare
  // ====================
  always @(negedge cpuClock) begin
    if (m_init) begin
      if (exp_valid && !i_rd_valid) begin
        error_count++;
        $display("Read of port %h in %s gave no o_rd_valid pulse", exp_port, test_name);
      end else if (!exp_valid && i_rd_valid) begin
        error_count++;
        $display("o_rd_valid pulsed without a read in %s", test_name);
      end else if (exp_valid) begin
        compare("rdata", {8'b0, exp_byte}, {8'b0, i_rdata});
      end
      compare("mem_ctrl", {8'b0, m_mem_ctrl}, {8'b0, i_mem_ctrl});
      compare("mode", {13'b0, ref_mode()}, {13'b0, i_mode});
      compare("name_table", {2'b0, m_regs[2][3:1], 11'b0}, {2'b0, i_name_table_addr});
      compare("sprite_pattern", {2'b0, ref_sprite_base()}, {2'b0, i_sprite_pattern_addr});
      compare("n_int", {15'b0, !(m_int && m_regs[1][5])}, {15'b0, i_n_int});
    end
  end

endmodule

//--- hw/sms_io_top.sv
`timescale 1ns/1ps

module sms_io_top (
  input  logic               cpuClock,
  input  logic               n_hard_reset,
  input  logic               i_io_wr,
  input  logic               i_io_rd,
  input  sms_pkg::byte_t     i_port,
  input  sms_pkg::byte_t     i_wdata,
  input  logic [6:0]         i_btn,
  input  logic               i_frame_irq,
  input  logic               i_sprite_collision,
  input  logic               i_too_many_sprites,
  input  logic [4:0]         i_sprite5,
  output sms_pkg::byte_t     o_rdata,
  output logic               o_rd_valid,
  output sms_pkg::byte_t     o_mem_ctrl,
  output logic               o_n_int,
  output sms_pkg::vdp_mode_e o_mode,
  output sms_pkg::vdp_addr_t o_name_table_addr,
  output sms_pkg::vdp_addr_t o_sprite_pattern_addr
);

  import sms_pkg::*;

  vdp_addr_t vram_addr;
  logic      cram_sel;
  logic      vblank_irq_en;
  byte_t     vram_rdata;
  byte_t     status_byte;

  vdp_bus_if vdp_bus ();

  // ====================
  // Port decode
  // ====================
  sms_io_decode i_sms_io_decode (
    .cpuClock      (cpuClock),
    .n_hard_reset  (n_hard_reset),
    .i_io_wr       (i_io_wr),
    .i_io_rd       (i_io_rd),
    .i_port        (i_port),
    .i_wdata       (i_wdata),
    .i_btn         (i_btn),
    .i_vram_rdata  (vram_rdata),
    .i_status_byte (status_byte),
    .bus           (vdp_bus.decoder),
    .o_rdata       (o_rdata),
    .o_rd_valid    (o_rd_valid),
    .o_mem_ctrl    (o_mem_ctrl)
  );

  // ====================
  // VDP side
  // ====================
  vdp_ctrl_regs i_vdp_ctrl_regs (
    .cpuClock              (cpuClock),
    .n_hard_reset          (n_hard_reset),
    .bus                   (vdp_bus.regs),
    .o_vram_addr           (vram_addr),
    .o_cram_sel            (cram_sel),
    .o_vblank_irq_en       (vblank_irq_en),
    .o_mode                (o_mode),
    .o_name_table_addr     (o_name_table_addr),
    .o_sprite_pattern_addr (o_sprite_pattern_addr)
  );

  vdp_vram i_vdp_vram (
    .cpuClock   (cpuClock),
    .bus        (vdp_bus.mem),
    .i_addr     (vram_addr),
    .i_cram_sel (cram_sel),
    .o_rdata    (vram_rdata)
  );

  // Event pulses come from the external renderer
  vdp_status i_vdp_status (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .bus                (vdp_bus.stat),
    .i_frame_irq        (i_frame_irq),
    .i_sprite_collision (i_sprite_collision),
    .i_too_many_sprites (i_too_many_sprites),
    .i_sprite5          (i_sprite5),
    .i_vblank_irq_en    (vblank_irq_en),
    .o_status_byte      (status_byte),
    .o_n_int            (o_n_int)
  );

endmodule

//--- hw/vdp_status.sv
`timescale 1ns/1ps

module vdp_status (
  input  logic           cpuClock,
  input  logic           n_hard_reset,
  vdp_bus_if.stat        bus,
  input  logic           i_frame_irq,
  input  logic           i_sprite_collision,
  input  logic           i_too_many_sprites,
  input  logic [4:0]     i_sprite5,
  input  logic           i_vblank_irq_en,
  output sms_pkg::byte_t o_status_byte,
  output logic           o_n_int
);

  import sms_pkg::*;

  logic r_int_flag;
  logic r_collision;

  // Set beats the clear from a status read
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      r_int_flag  <= 1'b0;
      r_collision <= 1'b0;
    end else begin
      r_int_flag  <= i_frame_irq        || (r_int_flag  && !bus.ctrl_rd);
      r_collision <= i_sprite_collision || (r_collision && !bus.ctrl_rd);
    end
  end

  assign o_status_byte = {r_int_flag, i_too_many_sprites, r_collision,
                          (i_too_many_sprites ? i_sprite5 : 5'h1F)};

  assign o_n_int = !(r_int_flag && i_vblank_irq_en);  // Active low

endmodule

//--- hw/vdp_vram.sv
`timescale 1ns/1ps

module vdp_vram (
  input  logic               cpuClock,
  vdp_bus_if.mem             bus,
  input  sms_pkg::vdp_addr_t i_addr,
  input  logic               i_cram_sel,
  output sms_pkg::byte_t     o_rdata
);

  import sms_pkg::*;

  byte_t vram [2**VRAM_AW];
  byte_t cram [2**CRAM_AW];   // Palette

  logic [CRAM_AW-1:0] cram_addr;

  assign cram_addr = i_addr[CRAM_AW-1:0];

  always_ff @(posedge cpuClock) begin
    if (bus.data_wr) begin
      if (i_cram_sel) begin
        cram[cram_addr] <= bus.wdata;
      end else begin
        vram[i_addr] <= bus.wdata;
      end
    end
  end

  // Pointer before its step, the step lands on the same edge
  always_ff @(posedge cpuClock) begin
    if (bus.data_rd) begin
      o_rdata <= i_cram_sel ? cram[cram_addr] : vram[i_addr];
    end
  end

endmodule

//--- hw/vdp_ctrl_regs.sv
`timescale 1ns/1ps

module vdp_ctrl_regs (
  input  logic               cpuClock,
  input  logic               n_hard_reset,
  vdp_bus_if.regs            bus,
  output sms_pkg::vdp_addr_t o_vram_addr,
  output logic               o_cram_sel,
  output logic               o_vblank_irq_en,
  output sms_pkg::vdp_mode_e o_mode,
  output sms_pkg::vdp_addr_t o_name_table_addr,
  output sms_pkg::vdp_addr_t o_sprite_pattern_addr
);

  import sms_pkg::*;

  byte_t     r_vdp [VDP_NUM_REGS];
  byte_t     r_first;       // First control byte
  logic      r_second;      // Next control write is the second byte
  vdp_addr_t r_addr;
  logic      r_cram_sel;

  vdp_cmd_e  cmd;
  vdp_addr_t cram_ptr;
  logic      reg_idx_ok;
  vdp_mode_e mode;

  assign cmd        = vdp_cmd_e'(bus.wdata[7:6]);
  assign cram_ptr   = vdp_addr_t'(r_first[5:0]);
  assign reg_idx_ok = (bus.wdata[3:0] < VDP_NUM_REGS);

  // ====================
  // Control port
  // ====================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      r_first    <= '0;
      r_second   <= 1'b0;
      r_addr     <= '0;
      r_cram_sel <= 1'b0;
      for (int i = 0; i < VDP_NUM_REGS; i++) begin
        r_vdp[i] <= '0;
      end
    end else if (bus.ctrl_wr) begin
      r_second <= ~r_second;
      if (!r_second) begin
        r_first <= bus.wdata;
      end else begin
        case (cmd)
          CMD_VRAM_RD, CMD_VRAM_WR: begin
            // Read or write direction is not tracked
            r_addr     <= {bus.wdata[5:0], r_first};
            r_cram_sel <= 1'b0;
          end
          CMD_REG_WR: begin
            if (reg_idx_ok) begin
              r_vdp[bus.wdata[3:0]] <= r_first;
            end else begin
              r_addr     <= cram_ptr;  // Out of range index falls to CRAM
              r_cram_sel <= 1'b1;
            end
          end
          CMD_CRAM_WR: begin
            r_addr     <= cram_ptr;
            r_cram_sel <= 1'b1;
          end
        endcase
      end
    end else if (bus.ctrl_rd) begin
      r_second <= 1'b0;  // Status read resyncs the byte pair
    end else if (bus.data_rd || bus.data_wr) begin
      r_second <= 1'b0;
      r_addr   <= r_addr + 1'b1;  // Wraps at 16K
    end
  end

  // ====================
  // Mode decode
  // ====================
  always_comb begin
    if (r_vdp[0][2]) begin
      mode = MODE_4;
    end else if (r_vdp[1][3]) begin
      mode = MODE_3;
    end else if (r_vdp[0][1]) begin
      mode = MODE_2;
    end else if (r_vdp[1][4]) begin
      mode = MODE_1;
    end else begin
      mode = MODE_0;
    end
  end

  // Table bases in VRAM
  assign o_name_table_addr = {r_vdp[2][3:1], 11'b0};
  assign o_sprite_pattern_addr = (mode == MODE_4) ? {r_vdp[6][2], 13'b0}
                                                  : {r_vdp[6][2:0], 11'b0};

  assign o_mode          = mode;
  assign o_vblank_irq_en = r_vdp[1][5];
  assign o_vram_addr     = r_addr;
  assign o_cram_sel      = r_cram_sel;

endmodule

//--- hw/sms_io_decode.sv
`timescale 1ns/1ps

module sms_io_decode (
  input  logic          cpuClock,
  input  logic          n_hard_reset,
  input  logic          i_io_wr,
  input  logic          i_io_rd,
  input  sms_pkg::byte_t i_port,
  input  sms_pkg::byte_t i_wdata,
  input  logic [6:0]    i_btn,
  input  sms_pkg::byte_t i_vram_rdata,
  input  sms_pkg::byte_t i_status_byte,
  vdp_bus_if.decoder    bus,
  output sms_pkg::byte_t o_rdata,
  output logic          o_rd_valid,
  output sms_pkg::byte_t o_mem_ctrl
);

  import sms_pkg::*;

  byte_t joy_byte;
  byte_t rd_byte;     // Read value for everything but the data port
  byte_t r_rd_byte;
  logic  r_rd_vram;   // Return comes from VRAM/CRAM
  logic  r_rd_valid;
  byte_t r_mem_ctrl;

  // ====================
  // VDP strobes
  // ====================
  assign bus.ctrl_wr = i_io_wr && (i_port == VDP_CTRL_PORT);
  assign bus.ctrl_rd = i_io_rd && (i_port == VDP_CTRL_PORT);
  assign bus.data_wr = i_io_wr && (i_port == VDP_DATA_PORT);
  assign bus.data_rd = i_io_rd && (i_port == VDP_DATA_PORT);
  assign bus.wdata   = i_wdata;

  // Buttons are active high here, the pad reads active low
  assign joy_byte = {~i_btn[2:1], ~i_btn[6:1]};

  always_comb begin
    case (i_port)
      VDP_CTRL_PORT:                      rd_byte = i_status_byte;
      JOY_PORT_0, JOY_PORT_1, JOY_PORT_2: rd_byte = joy_byte;
      default:                            rd_byte = OPEN_BUS;
    endcase
  end

  // Memory control register, write only
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      r_mem_ctrl <= MEM_CTRL_RESET;
    end else if (i_io_wr && (i_port == MEM_CTRL_PORT)) begin
      r_mem_ctrl <= i_wdata;
    end
  end

  // ====================
  // Read return
  // ====================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      r_rd_valid <= 1'b0;
    end else begin
      r_rd_valid <= i_io_rd;
    end
  end

  always_ff @(posedge cpuClock) begin
    if (i_io_rd) begin
      r_rd_byte <= rd_byte;
      r_rd_vram <= (i_port == VDP_DATA_PORT);  // VRAM registers its own byte
    end
  end

  assign o_rdata    = r_rd_vram ? i_vram_rdata : r_rd_byte;
  assign o_rd_valid = r_rd_valid;
  assign o_mem_ctrl = r_mem_ctrl;

endmodule

//--- hw/vdp_bus_if.sv
`timescale 1ns/1ps

interface vdp_bus_if;

  logic       ctrl_wr;  // Port BF write
  logic       ctrl_rd;  // Port BF read, status
  logic       data_wr;  // Port BE write
  logic       data_rd;  // Port BE read
  logic [7:0] wdata;

  modport decoder (output ctrl_wr, ctrl_rd, data_wr, data_rd, wdata);

  modport regs (input ctrl_wr, ctrl_rd, data_wr, data_rd, wdata);

  modport mem (input data_wr, data_rd, wdata);

  modport stat (input ctrl_rd);

endinterface

//--- hw/sms_pkg.sv
package sms_pkg;

  // ====================
  // Widths
  // ====================
  localparam int PORT_W       = 8;
  localparam int VRAM_AW      = 14;
  localparam int CRAM_AW      = 5;
  localparam int VDP_NUM_REGS = 11;  // Registers 0 to 10

  typedef logic [PORT_W-1:0]  byte_t;
  typedef logic [VRAM_AW-1:0] vdp_addr_t;

  // ====================
  // I/O port map
  // ====================
  localparam byte_t VDP_DATA_PORT = 8'hBE;
  localparam byte_t VDP_CTRL_PORT = 8'hBF;
  localparam byte_t MEM_CTRL_PORT = 8'h3E;
  localparam byte_t JOY_PORT_0    = 8'hDC;  // All three return the same pad byte
  localparam byte_t JOY_PORT_1    = 8'hDD;
  localparam byte_t JOY_PORT_2    = 8'hDE;

  localparam byte_t MEM_CTRL_RESET = 8'hF7;
  localparam byte_t OPEN_BUS       = 8'hFF;  // Nothing drives the bus

  typedef enum logic [2:0] {
    MODE_0 = 3'd0,
    MODE_1 = 3'd1,
    MODE_2 = 3'd2,
    MODE_3 = 3'd3,
    MODE_4 = 3'd4
  } vdp_mode_e;

  // Top two bits of the second control byte
  typedef enum logic [1:0] {
    CMD_VRAM_RD = 2'd0,
    CMD_VRAM_WR = 2'd1,
    CMD_REG_WR  = 2'd2,
    CMD_CRAM_WR = 2'd3
  } vdp_cmd_e;

endpackage
